// ==== src/tlp_rx_packer.sv ====
/*
 * receive packer
 * collects 64-bit core beats into 128-bit user beats, filling from
 * dword 0 upward. a user beat leaves once three or more dwords are held
 * or the packet has ended. no back-pressure in either direction
 */

`timescale 1ns/1ps
`include "tlp_width_bridge_config.svh"

module tlp_rx_packer import tlp_width_bridge_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,

    // core side
    input  core_beat_t core_rx,
    input  logic       core_rx_valid,

    // user side, lite source
    output user_beat_t user_rx,
    output logic       user_rx_valid
);

    // ------------------------------
    // state
    // ------------------------------

    logic [2:0] dw_count;       // dwords held, 0 to 4
    logic       rx_first;
    logic       rx_last;        // packet end captured
    user_data_t asm_data;       // assembly register
    bar_hit_t   asm_bar_hit;

    logic       emit;
    logic [2:0] next_base;
    logic [2:0] next_count;
    dword_t     rx_lo_dw;
    dword_t     rx_hi_dw;

    // ------------------------------
    // next offset and beat emit
    // ------------------------------

    // a user beat goes out this cycle
    assign emit = rx_last || (dw_count > 3'd2);

    // an emitted beat frees the whole register
    assign next_base  = emit ? 3'd0 : dw_count;
    assign next_count = next_base + 3'd1 + {2'b00, core_rx.hi_valid};

    assign rx_lo_dw = core_rx.data[`TLP_DW_BITS-1:0];
    assign rx_hi_dw = core_rx.data[2*`TLP_DW_BITS-1:`TLP_DW_BITS];

    // ------------------------------
    // control
    // ------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            dw_count <= 3'd0;
            rx_first <= 1'b1;
            rx_last  <= 1'b0;
        end else if (core_rx_valid) begin
            dw_count <= next_count;
            rx_last  <= core_rx.last;
            if (emit) begin
                rx_first <= rx_last;    // next packet starts fresh
            end
        end else if (emit) begin
            dw_count <= 3'd0;
            rx_last  <= 1'b0;
            rx_first <= rx_last;
        end
    end

    // dword writes at the current offset
    always_ff @(posedge clk_pcie) begin
        if (core_rx_valid) begin
            asm_data[next_base*`TLP_DW_BITS +: `TLP_DW_BITS] <= rx_lo_dw;
            if (core_rx.hi_valid) begin
                asm_data[(next_base+3'd1)*`TLP_DW_BITS +: `TLP_DW_BITS] <= rx_hi_dw;
            end
            asm_bar_hit <= core_rx.bar_hit;     // most recent beat wins
        end
    end

    // ------------------------------
    // user beat
    // ------------------------------

    assign user_rx_valid   = emit;
    assign user_rx.data    = asm_data;
    assign user_rx.keep_dw = {dw_count > 3'd3, dw_count > 3'd2, dw_count > 3'd1, 1'b1};
    assign user_rx.first   = rx_first;
    assign user_rx.last    = rx_last;
    assign user_rx.bar_hit = asm_bar_hit;

endmodule

// ==== src/tlp_tx_splitter.sv ====
/*
 * transmit splitter
 * sends the lower half of a 128-bit user beat straight to the core,
 * then the upper half from a register when keep_dw[2] is set. the user
 * beat is released only once every half it needs has been accepted
 */

`timescale 1ns/1ps
`include "tlp_width_bridge_config.svh"

module tlp_tx_splitter import tlp_width_bridge_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,

    // user side
    input  user_beat_t user_tx,
    input  logic       user_tx_valid,
    output logic       user_tx_ready,

    // core side
    output core_beat_t core_tx,
    output logic       core_tx_valid,
    input  logic       core_tx_ready
);

    tx_state_t  state;
    core_beat_t pend_beat;      // registered upper half
    core_beat_t lower_beat;
    logic       two_half;       // user beat needs a second core beat

    assign two_half = user_tx.keep_dw[2];

    // ------------------------------
    // lower half without a register
    // ------------------------------

    assign lower_beat.data     = user_tx.data[`TLP_CORE_DWORDS*`TLP_DW_BITS-1:0];
    assign lower_beat.hi_valid = user_tx.keep_dw[1];
    assign lower_beat.last     = user_tx.last && !two_half;
    assign lower_beat.bar_hit  = user_tx.bar_hit;

    // ------------------------------
    // FSM
    // ------------------------------

    always_ff @(posedge clk_pcie) begin
        if (rst) begin
            state <= TX_LOWER;
        end else begin
            case (state)
                TX_LOWER: begin
                    if (user_tx_valid && core_tx_ready && two_half) begin
                        state <= TX_UPPER;
                    end
                end
                TX_UPPER: begin
                    if (core_tx_ready) begin
                        state <= TX_RETIRE;
                    end
                end
                default: begin
                    if (core_tx_ready) begin
                        state <= TX_LOWER;  // user beat taken this cycle
                    end
                end
            endcase
        end
    end

    // upper half loads only as the lower half of a two-half beat is accepted
    always_ff @(posedge clk_pcie) begin
        if (state == TX_LOWER && user_tx_valid && core_tx_ready && two_half) begin
            pend_beat.data     <= user_tx.data[`TLP_USER_DWORDS*`TLP_DW_BITS-1:
                                               `TLP_CORE_DWORDS*`TLP_DW_BITS];
            pend_beat.hi_valid <= user_tx.keep_dw[3];
            pend_beat.last     <= user_tx.last;
            pend_beat.bar_hit  <= user_tx.bar_hit;
        end
    end

    // ------------------------------
    // outputs
    // ------------------------------

    assign core_tx       = (state == TX_UPPER) ? pend_beat : lower_beat;
    assign core_tx_valid = (state == TX_UPPER) || (state == TX_LOWER && user_tx_valid);

    assign user_tx_ready = core_tx_ready &&
                           ((state == TX_LOWER && !(user_tx_valid && two_half)) ||
                            state == TX_RETIRE);

endmodule

// ==== src/tlp_width_bridge.sv ====
/*
 * tlp width bridge
 * data-path core between the 64-bit PCIe core stream and the 128-bit
 * user stream. receive beats are packed, transmit beats are split
 */

`timescale 1ns/1ps
`include "tlp_width_bridge_config.svh"

module tlp_width_bridge import tlp_width_bridge_pkg::*; (
    input  logic       clk_pcie,
    input  logic       rst,

    // receive, core to user
    input  core_beat_t core_rx,
    input  logic       core_rx_valid,
    output user_beat_t user_rx,
    output logic       user_rx_valid,

    // transmit, user to core
    input  user_beat_t user_tx,
    input  logic       user_tx_valid,
    output logic       user_tx_ready,
    output core_beat_t core_tx,
    output logic       core_tx_valid,
    input  logic       core_tx_ready
);

    // ------------------------------
    // receive path
    // ------------------------------

    tlp_rx_packer u_rx_packer (
        .clk_pcie      ( clk_pcie      ),
        .rst           ( rst           ),
        .core_rx       ( core_rx       ),   // <- 64-bit core beat
        .core_rx_valid ( core_rx_valid ),
        .user_rx       ( user_rx       ),   // -> 128-bit user beat
        .user_rx_valid ( user_rx_valid )
    );

    // ------------------------------
    // transmit path
    // ------------------------------

    tlp_tx_splitter u_tx_splitter (
        .clk_pcie      ( clk_pcie      ),
        .rst           ( rst           ),
        .user_tx       ( user_tx       ),   // <- 128-bit user beat
        .user_tx_valid ( user_tx_valid ),
        .user_tx_ready ( user_tx_ready ),
        .core_tx       ( core_tx       ),   // -> 64-bit core beat
        .core_tx_valid ( core_tx_valid ),
        .core_tx_ready ( core_tx_ready )
    );

endmodule

// ==== src/tlp_width_bridge_config.svh ====
/*
 * tlp width bridge configuration
 * fixed widths of the 64-bit PCIe core stream and the 128-bit user
 * stream, plus the one-hot BAR-hit field carried beside the data
 */

`ifndef TLP_WIDTH_BRIDGE_CONFIG_SVH
`define TLP_WIDTH_BRIDGE_CONFIG_SVH

// ------------------------------
// dword and beat geometry
// ------------------------------

// bits in one dword
`define TLP_DW_BITS         32

// dwords per core beat, 64-bit core interface
`define TLP_CORE_DWORDS     2

// dwords per user beat, 128-bit user stream
`define TLP_USER_DWORDS     4

// ------------------------------
// sideband
// ------------------------------

// one bit per BAR plus expansion ROM
`define TLP_BAR_HIT_BITS    7

`endif

// ==== src/tlp_width_bridge_pkg.sv ====
/*
 * tlp width bridge types
 * vector typedefs for dwords, beat data, keep and BAR hit, and the
 * packed beat structs used on both sides of the bridge
 */

`include "tlp_width_bridge_config.svh"

package tlp_width_bridge_pkg;

    // ------------------------------
    // plain vectors
    // ------------------------------

    typedef logic [`TLP_DW_BITS-1:0]                     dword_t;
    typedef logic [`TLP_CORE_DWORDS*`TLP_DW_BITS-1:0]    core_data_t;
    typedef logic [`TLP_USER_DWORDS*`TLP_DW_BITS-1:0]    user_data_t;
    typedef logic [`TLP_USER_DWORDS-1:0]                 dw_keep_t;    // one bit per user dword
    typedef logic [`TLP_BAR_HIT_BITS-1:0]                bar_hit_t;    // one-hot

    // ------------------------------
    // beats
    // ------------------------------

    // one 64-bit beat as seen by the PCIe core
    typedef struct packed {
        core_data_t data;
        logic       hi_valid;   // upper dword carries data
        logic       last;       // final beat of the tlp
        bar_hit_t   bar_hit;
    } core_beat_t;

    // one 128-bit beat on the user stream
    typedef struct packed {
        user_data_t data;
        dw_keep_t   keep_dw;    // low bits set, contiguous
        logic       first;      // first beat of the tlp
        logic       last;       // beat with the final dword
        bar_hit_t   bar_hit;
    } user_beat_t;

    // ------------------------------
    // transmit splitter FSM
    // ------------------------------

    typedef enum logic [1:0] {
        TX_LOWER  = 2'd0,   // lower half straight from the user beat
        TX_UPPER  = 2'd1,   // registered upper half on the core side
        TX_RETIRE = 2'd2    // both halves gone, release the user beat
    } tx_state_t;

endpackage

// ==== tb/tb_tlp_width_bridge.sv ====
/*
 * testbench for the tlp width bridge
 * directed receive, transmit, back-pressure and reset tests, checked
 * against queue models of both streams
 */

`timescale 1ns/1ps
`include "tlp_width_bridge_config.svh"

module tb_tlp_width_bridge import tlp_width_bridge_pkg::*; ();

    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = RESET_CYCLES + 6 * 300;   // six tests at their worst case

    logic       clk_pcie;
    logic       rst;
    core_beat_t core_rx;
    logic       core_rx_valid;
    user_beat_t user_rx;
    logic       user_rx_valid;
    user_beat_t user_tx;
    logic       user_tx_valid;
    logic       user_tx_ready;
    core_beat_t core_tx;
    logic       core_tx_valid;
    logic       core_tx_ready;

    integer     seed;
    int         errors;
    int         checks;
    logic       bp_mode;                // random core_tx_ready
    dw_keep_t   keep_opts [4] = '{4'h1, 4'h3, 4'h7, 4'hf};
    user_beat_t rx_exp_q [$];
    user_beat_t rx_got_q [$];
    core_beat_t tx_exp_q [$];
    core_beat_t tx_got_q [$];

    tlp_width_bridge DUT (.*);

    initial clk_pcie = 1'b0;
    always #10 clk_pcie = ~clk_pcie;

    initial begin
        #(TEST_CYCLES * 20 + 2000);
        $display("watchdog expired, the tests did not finish in time");
        $display("Test FAILED");
        $finish;
    end

    always @(posedge clk_pcie) begin
        #2;
        core_tx_ready = bp_mode ? $random(seed) : 1'b1;
    end

    // ------------------------------
    // monitors on the falling edge
    // ------------------------------

    always @(negedge clk_pcie) begin
        if (!rst && user_rx_valid) begin
            rx_got_q.push_back(user_rx);
        end
        if (!rst && core_tx_valid && core_tx_ready) begin
            tx_got_q.push_back(core_tx);
        end
        // every half of a user beat must be out before it is released
        if (!rst && user_tx_valid && user_tx_ready && tx_got_q.size() != tx_exp_q.size()) begin
            $display("user_tx_ready rose at %0d ns before the upper half went out", $time);
            errors++;
        end
    end

    function automatic dword_t rand_dw();
        return $random(seed);
    endfunction

    task automatic drive_slot();
        @(posedge clk_pcie);
        #2;
    endtask

    task automatic report_value(input string what, input logic [127:0] exp,
                                input logic [127:0] got);
        $display("[FAIL] %0d ns: %s, expected %0h, got %0h", $time, what, exp, got);
        errors++;
    endtask

    // ------------------------------
    // stimulus and models
    // ------------------------------

    task automatic send_rx_packet(input int n_dw, input bar_hit_t bar);
        dword_t     dw [$];
        user_beat_t ub;
        int         i;
        int         k;
        for (i = 0; i <= n_dw; i++) begin
            dw.push_back(rand_dw());    // one spare for a half tail
        end
        for (i = 0; i < n_dw; i += 4) begin
            ub = '0;
            for (k = 0; k < 4 && i + k < n_dw; k++) begin
                ub.data[k*`TLP_DW_BITS +: `TLP_DW_BITS] = dw[i+k];
                ub.keep_dw[k] = 1'b1;
            end
            ub.first   = (i == 0);
            ub.last    = (i + 4 >= n_dw);
            ub.bar_hit = bar;
            rx_exp_q.push_back(ub);
        end
        for (i = 0; i < n_dw; i += 2) begin
            drive_slot();
            core_rx.data     = {dw[i+1], dw[i]};
            core_rx.hi_valid = (i + 1 < n_dw);
            core_rx.last     = (i + 2 >= n_dw);
            core_rx.bar_hit  = bar;
            core_rx_valid    = 1'b1;
        end
    endtask

    task automatic rx_idle();
        drive_slot();
        core_rx_valid = 1'b0;
    endtask

    // starts at a drive slot and returns at the slot after the handshake
    task automatic send_tx_beat(input dw_keep_t keep, input logic last, input bar_hit_t bar);
        user_beat_t ub;
        core_beat_t cb;
        int         n;
        ub.data    = {rand_dw(), rand_dw(), rand_dw(), rand_dw()};
        ub.keep_dw = keep;
        ub.first   = 1'b1;
        ub.last    = last;
        ub.bar_hit = bar;
        cb.data     = ub.data[63:0];
        cb.hi_valid = keep[1];
        cb.last     = last && !keep[2];
        cb.bar_hit  = bar;
        tx_exp_q.push_back(cb);
        if (keep[2]) begin
            cb.data     = ub.data[127:64];
            cb.hi_valid = keep[3];
            cb.last     = last;
            tx_exp_q.push_back(cb);
        end
        user_tx       = ub;
        user_tx_valid = 1'b1;
        n = 0;
        @(negedge clk_pcie);
        while (!user_tx_ready && n < 100) begin
            @(negedge clk_pcie);
            n++;
        end
        if (!user_tx_ready) begin
            $display("user_tx_ready never rose for a transmit beat");
            errors++;
        end
        drive_slot();
        user_tx_valid = 1'b0;
    endtask

    task automatic send_tx_random(input int count);
        repeat (count) begin
            send_tx_beat(keep_opts[$random(seed) & 3], $random(seed) & 1, 7'h02);
        end
    endtask

    task automatic check_streams(input string name);
        user_beat_t ue;
        user_beat_t ug;
        core_beat_t ce;
        core_beat_t cg;
        user_data_t umask;
        int         i;
        int         k;
        i = 0;
        while ((rx_got_q.size() < rx_exp_q.size() || tx_got_q.size() < tx_exp_q.size())
               && i < 60) begin
            @(posedge clk_pcie);
            i++;
        end
        repeat (4) @(posedge clk_pcie);     // room for stray beats
        if (rx_got_q.size() != rx_exp_q.size() || tx_got_q.size() != tx_exp_q.size()) begin
            $display("%s: beat count wrong, rx %0d of %0d, tx %0d of %0d", name,
                     rx_got_q.size(), rx_exp_q.size(), tx_got_q.size(), tx_exp_q.size());
            errors++;
        end
        for (i = 0; i < rx_exp_q.size() && i < rx_got_q.size(); i++) begin
            ue = rx_exp_q[i];
            ug = rx_got_q[i];
            for (k = 0; k < 4; k++) begin
                umask[k*`TLP_DW_BITS +: `TLP_DW_BITS] = {`TLP_DW_BITS{ue.keep_dw[k]}};
            end
            checks++;
            if ({ug.keep_dw, ug.first, ug.last, ug.bar_hit} !==
                {ue.keep_dw, ue.first, ue.last, ue.bar_hit}) begin
                report_value($sformatf("%s rx beat %0d keep/first/last/bar_hit", name, i),
                             {ue.keep_dw, ue.first, ue.last, ue.bar_hit},
                             {ug.keep_dw, ug.first, ug.last, ug.bar_hit});
            end
            if ((ug.data & umask) !== (ue.data & umask)) begin
                report_value($sformatf("%s rx beat %0d data", name, i),
                             ue.data & umask, ug.data & umask);
            end
        end
        for (i = 0; i < tx_exp_q.size() && i < tx_got_q.size(); i++) begin
            ce = tx_exp_q[i];
            cg = tx_got_q[i];
            checks++;
            if ({cg.hi_valid, cg.last, cg.bar_hit} !== {ce.hi_valid, ce.last, ce.bar_hit}) begin
                report_value($sformatf("%s tx beat %0d hi_valid/last/bar_hit", name, i),
                             {ce.hi_valid, ce.last, ce.bar_hit},
                             {cg.hi_valid, cg.last, cg.bar_hit});
            end
            if (cg.data[31:0] !== ce.data[31:0] ||
                (ce.hi_valid && cg.data[63:32] !== ce.data[63:32])) begin
                report_value($sformatf("%s tx beat %0d data", name, i), ce.data, cg.data);
            end
        end
        rx_exp_q.delete();
        rx_got_q.delete();
        tx_exp_q.delete();
        tx_got_q.delete();
    endtask

    // ------------------------------
    // directed tests
    // ------------------------------

    task automatic test_rx_whole();
        send_rx_packet(4, 7'h01);
        send_rx_packet(8, 7'h02);
        send_rx_packet(12, 7'h04);
        rx_idle();
        check_streams("rx whole beats");
    endtask

    task automatic test_rx_tail();
        send_rx_packet(5, 7'h08);
        send_rx_packet(6, 7'h10);
        send_rx_packet(7, 7'h20);
        rx_idle();
        check_streams("rx partial tail");
    endtask

    task automatic test_tx_halves();
        drive_slot();
        send_tx_beat(4'h1, 1'b1, 7'h01);
        send_tx_beat(4'h3, 1'b1, 7'h02);
        send_tx_beat(4'h7, 1'b1, 7'h04);
        send_tx_beat(4'hf, 1'b1, 7'h08);
        send_tx_beat(4'hf, 1'b0, 7'h10);   // two-beat packet
        send_tx_beat(4'h7, 1'b1, 7'h10);
        check_streams("tx halves");
    endtask

    task automatic test_tx_backpressure();
        bp_mode = 1'b1;
        drive_slot();
        send_tx_random(16);
        bp_mode = 1'b0;
        check_streams("tx back-pressure");
    endtask

    task automatic test_both_paths();
        fork
            begin
                send_rx_packet(8, 7'h01);
                send_rx_packet(5, 7'h02);
                send_rx_packet(12, 7'h04);
                send_rx_packet(6, 7'h08);
                rx_idle();
            end
            begin
                bp_mode = 1'b1;
                drive_slot();
                send_tx_random(12);
                bp_mode = 1'b0;
            end
        join
        check_streams("both paths");
    endtask

    task automatic test_reset_mid_packet();
        user_beat_t ub;
        int         i;
        ub = '0;
        ub.keep_dw = 4'hf;
        ub.first   = 1'b1;
        ub.bar_hit = 7'h40;
        // three core beats of a longer packet so only the first user beat leaves
        for (i = 0; i < 3; i++) begin
            drive_slot();
            core_rx = '{data: {rand_dw(), rand_dw()}, hi_valid: 1'b1, last: 1'b0,
                        bar_hit: 7'h40};
            if (i < 2) begin
                ub.data[i*64 +: 64] = core_rx.data;
            end
            core_rx_valid = 1'b1;
        end
        rx_exp_q.push_back(ub);
        drive_slot();
        core_rx_valid = 1'b0;
        rst = 1'b1;
        drive_slot();
        drive_slot();
        rst = 1'b0;
        repeat (6) begin
            @(negedge clk_pcie);
            if (user_rx_valid) begin
                $display("user_rx_valid rose after reset with no new receive input");
                errors++;
            end
        end
        send_rx_packet(4, 7'h20);
        rx_idle();
        check_streams("reset mid-packet");
    endtask

    initial begin
        seed          = 32'haf52_602d;
        errors        = 0;
        checks        = 0;
        bp_mode       = 1'b0;
        rst           = 1'b1;
        core_rx       = '0;
        core_rx_valid = 1'b0;
        user_tx       = '0;
        user_tx_valid = 1'b0;
        core_tx_ready = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_pcie);
        #2;
        rst = 1'b0;
        test_rx_whole();
        test_rx_tail();
        test_tx_halves();
        test_tx_backpressure();
        test_both_paths();
        test_reset_mid_packet();
        errors += DUT.u_check.assert_failures;
        $display("closing report: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== tb/tlp_width_bridge_assert.sv ====
/*
 * bridge assertions
 * core transmit beat held under back-pressure, quiet outputs after
 * reset and contiguous keep on the receive user stream
 */

`timescale 1ns/1ps

module tlp_width_bridge_assert import tlp_width_bridge_pkg::*; (
    input logic       clk_pcie,
    input logic       rst,
    input user_beat_t user_rx,
    input logic       user_rx_valid,
    input core_beat_t core_tx,
    input logic       core_tx_valid,
    input logic       core_tx_ready
);

    int assert_failures = 0;    // failure tally

    // core beat stays put until the core takes it
    tx_hold: assert property (@(posedge clk_pcie) disable iff (rst)
        core_tx_valid && !core_tx_ready |=> core_tx_valid && $stable(core_tx))
    else begin
        $error("core_tx changed or dropped while core_tx_ready was low");
        assert_failures++;
    end

    quiet_after_reset: assert property (@(posedge clk_pcie)
        rst |=> !user_rx_valid && !core_tx_valid)
    else begin
        $error("a valid was high in the cycle after reset");
        assert_failures++;
    end

    // only the final beat of a packet may be short
    rx_keep_shape: assert property (@(posedge clk_pcie) disable iff (rst)
        user_rx_valid |-> (user_rx.keep_dw inside {4'b0001, 4'b0011, 4'b0111, 4'b1111})
                          && (user_rx.last || user_rx.keep_dw == 4'b1111))
    else begin
        $error("user_rx keep_dw is not contiguous or a short beat is not the last");
        assert_failures++;
    end

endmodule

bind tlp_width_bridge tlp_width_bridge_assert u_check (
    .clk_pcie      ( clk_pcie      ),
    .rst           ( rst           ),
    .user_rx       ( user_rx       ),
    .user_rx_valid ( user_rx_valid ),
    .core_tx       ( core_tx       ),
    .core_tx_valid ( core_tx_valid ),
    .core_tx_ready ( core_tx_ready )
);

// ==== tlp_width_bridge.f ====
+incdir+src
src/tlp_width_bridge_pkg.sv
src/tlp_rx_packer.sv
src/tlp_tx_splitter.sv
src/tlp_width_bridge.sv
tb/tlp_width_bridge_assert.sv
tb/tb_tlp_width_bridge.sv
